/* xc_trace.txt */
# C idle count bytes | P reps n (pattern len) x n idle | R ready_mode idle | E 19 packet bytes
# Ready mode 0 is always high, 1 is random, 2 is held low; counts decimal, bytes hex
E a5 01 33 00 05 05 00 04 05 00 00 05 00 00 00 00 00 00 00
E a5 02 33 00 04 04 00 00 04 00 04 00 00 00 00 00 00 00 00
E a5 03 33 00 04 04 00 00 04 00 00 04 00 00 00 00 00 00 00
E a5 04 33 00 04 04 05 04 04 05 04 00 00 00 00 00 00 00 00
E a5 05 33 00 ff ff 00 ff ff 00 ff ff ff 00 00 00 00 00 00
E a5 06 33 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
E a5 08 33 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
R 1 0
C 10 4 01 25 28 1d
P 5 2 3 1 0 1 60
P 4 3 1 1 2 1 0 4 20
C 10 2 01 14
P 4 3 1 1 2 1 0 4 20
C 15 3 00 21 22
P 4 3 1 1 2 1 0 4 0
P 1 1 4 5 49
C 20 6 0d 01 32 11 32 48
C 293 1 1d
C 20 6 0d 01 02 11 02 28
C 24 1 1d
R 2 120
R 1 80
C 30 1 0d

/* list.f */
xc_pkg.sv
pulse_conditioner.sv
tap_delay_line.sv
correlator_core.sv
command_decoder.sv
integration_timer.sv
packet_framer.sv
xc_top.sv
tb_xc.sv

/* tb_xc.sv */
// Correlator trace testbench
`timescale 1ns/1ps
`default_nettype none

module tb_xc;

	localparam int PKT_LEN = 19;

	logic        RXIF;
	logic        arst_n;
	logic [2:0]  line_in;
	logic [7:0]  cmd_data;
	logic        cmd_valid;
	logic        pkt_ready;
	wire  [7:0]  pkt_data;
	wire         pkt_valid;
	wire         pkt_last;

	logic [13:0] steps[$];      // Ready mode, cmd valid, cmd byte, line pattern
	logic [7:0]  exp_q[$];      // Expected packet bytes in arrival order
	logic [31:0] lcg_state;
	int          byte_idx;      // Position inside the current packet
	int          total_cycles;
	bit          loaded;

	xc_top dut_i (
		.RXIF(RXIF), .arst_n(arst_n), .line_in(line_in),
		.cmd_data(cmd_data), .cmd_valid(cmd_valid),
		.pkt_data(pkt_data), .pkt_valid(pkt_valid),
		.pkt_ready(pkt_ready), .pkt_last(pkt_last)
	);

	always #2 RXIF = ~RXIF;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic add_step(input logic [1:0] mode, input logic valid,
			input logic [7:0] cmd, input logic [2:0] lines);
		steps.push_back({mode, valid, cmd, lines});
	endtask

	task automatic load_trace();
		int         fd;
		int         rc;
		int         kind;
		int         reps;
		int         n;
		int         idle;
		int         k;
		int         len [8];
		logic [2:0] pat [8];
		logic [1:0] mode;
		logic [7:0] b;
		string      rest;
		mode = 2'd0;
		fd = $fopen("xc_trace.txt", "r");
		if (fd == 0) begin
			report_failure("Could not open the trace file xc_trace.txt");
		end else begin
			while ($fscanf(fd, " %c", kind) == 1) begin
				case (kind)
					"#": rc = $fgets(rest, fd);
					"E": begin
						for (int i = 0; i < PKT_LEN; i++) begin
							rc = $fscanf(fd, " %h", b);
							if (rc != 1) begin
								report_failure("The trace file ends inside an expected packet");
							end
							exp_q.push_back(b);
						end
					end
					"R": begin
						rc = $fscanf(fd, " %d %d", mode, idle);
						repeat (idle) add_step(mode, 1'b0, 8'h00, 3'b000);
					end
					"C": begin
						rc = $fscanf(fd, " %d %d", idle, k);
						repeat (k) begin
							rc = $fscanf(fd, " %h", b);
							add_step(mode, 1'b1, b, 3'b000);
						end
						repeat (idle) add_step(mode, 1'b0, 8'h00, 3'b000);
					end
					"P": begin
						rc = $fscanf(fd, " %d %d", reps, n);
						for (int i = 0; i < n; i++) begin
							rc = $fscanf(fd, " %h %d", pat[i], len[i]);
						end
						rc = $fscanf(fd, " %d", idle);
						repeat (reps) begin
							for (int i = 0; i < n; i++) begin
								repeat (len[i]) add_step(mode, 1'b0, 8'h00, pat[i]);
							end
						end
						repeat (idle) add_step(mode, 1'b0, 8'h00, 3'b000);
					end
					default: report_failure("The trace file holds an unknown record type");
				endcase
			end
			$fclose(fd);
		end
		total_cycles = steps.size();
	endtask

	// Compare every accepted byte, sampled away from the active edge
	always @(negedge RXIF) begin
		if (arst_n && pkt_valid && pkt_ready) begin
			assert (exp_q.size() > 0)
				else report_failure("A packet byte arrived when no packet was expected");
			assert (pkt_data == exp_q[0])
				else report_failure($sformatf("FAILED at %0t ns: byte %0d expected %02h, got %02h",
					$time, byte_idx, exp_q[0], pkt_data));
			assert (pkt_last == (byte_idx == PKT_LEN - 1))
				else report_failure($sformatf("pkt_last was %0b on packet byte %0d of %0d",
					pkt_last, byte_idx + 1, PKT_LEN));
			void'(exp_q.pop_front());
			byte_idx = (byte_idx == PKT_LEN - 1) ? 0 : byte_idx + 1;
		end
	end

	initial begin
		wait (loaded);
		#((2 * total_cycles + 300) * 4);  // Twice the trace length plus reset and drain
		report_failure("Timeout, the trace did not complete within the time limit");
	end

	initial begin
		logic [13:0] s;
		RXIF      = 1'b0;
		arst_n    = 1'b0;
		line_in   = '0;
		cmd_data  = '0;
		cmd_valid = 1'b0;
		pkt_ready = 1'b1;
		lcg_state = 32'hbe2f_d369;
		byte_idx  = 0;
		loaded    = 1'b0;
		load_trace();
		loaded = 1'b1;
		repeat (16) @(posedge RXIF);
		#1 arst_n = 1'b1;
		foreach (steps[i]) begin
			@(posedge RXIF);
			#1;
			s = steps[i];
			lcg_state = lcg_next(lcg_state);
			line_in   = s[2:0];
			cmd_data  = s[10:3];
			cmd_valid = s[11];
			case (s[13:12])
				2'd0: pkt_ready = 1'b1;
				2'd1: pkt_ready = (lcg_state[31:30] != 2'b00);  // Ready three cycles in four
				default: pkt_ready = 1'b0;
			endcase
		end
		@(posedge RXIF);
		#1;
		cmd_valid = 1'b0;
		line_in   = '0;
		pkt_ready = 1'b1;
		while (exp_q.size() != 0 || byte_idx != 0) @(posedge RXIF);
		repeat (100) @(posedge RXIF);  // Capture is off, nothing more may arrive
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

/* xc_top.sv */
// Photon correlator top level
`timescale 1ns/1ps
`default_nettype none

module xc_top (
	input  wire                          RXIF,
	input  wire                          arst_n,
	input  wire  [xc_pkg::NUM_INPUTS-1:0] line_in,
	input  wire  [7:0]                   cmd_data,
	input  wire                          cmd_valid,
	output logic [7:0]                   pkt_data,
	output logic                         pkt_valid,
	input  wire                          pkt_ready,
	output logic                         pkt_last
);
	import xc_pkg::*;

	wire [NUM_INPUTS-1:0]               line_invert;
	wire [NUM_INPUTS-1:0]               line_level;
	wire [NUM_INPUTS*DELAY_WIDTH-1:0]   cross_delay;
	wire [NUM_INPUTS*DELAY_WIDTH-1:0]   auto_delay;
	wire [WINDOW_SHIFT_WIDTH-1:0]       window_shift;
	wire                                capture;
	wire [NUM_INPUTS-1:0]               pulses;
	wire [NUM_TAPS*NUM_INPUTS-1:0]      taps;
	wire                                window_start;
	wire                                window_end;
	wire [NUM_COUNTERS*COUNT_WIDTH-1:0] counts;

	command_decoder decoder_i (
		.RXIF(RXIF), .arst_n(arst_n),
		.cmd_data(cmd_data), .cmd_valid(cmd_valid),
		.line_invert(line_invert), .line_level(line_level),
		.cross_delay(cross_delay), .auto_delay(auto_delay),
		.window_shift(window_shift), .capture(capture)
	);

	pulse_conditioner conditioner_i (
		.RXIF(RXIF), .arst_n(arst_n), .line_in(line_in),
		.line_invert(line_invert), .line_level(line_level), .pulses(pulses)
	);

	tap_delay_line delay_i (
		.RXIF(RXIF), .arst_n(arst_n), .pulses(pulses), .taps(taps)
	);

	correlator_core core_i (
		.RXIF(RXIF), .arst_n(arst_n), .taps(taps),
		.cross_delay(cross_delay), .auto_delay(auto_delay),
		.window_start(window_start), .counts(counts)
	);

	integration_timer timer_i (
		.RXIF(RXIF), .arst_n(arst_n),
		.capture(capture), .window_shift(window_shift),
		.window_start(window_start), .window_end(window_end)
	);

	packet_framer framer_i (
		.RXIF(RXIF), .arst_n(arst_n),
		.counts(counts), .window_end(window_end),
		.pkt_data(pkt_data), .pkt_valid(pkt_valid),
		.pkt_last(pkt_last), .pkt_ready(pkt_ready)
	);

endmodule

`default_nettype wire

/* packet_framer.sv */
// Result packet framer
`timescale 1ns/1ps
`default_nettype none

module packet_framer (
	input  wire                                                  RXIF,
	input  wire                                                  arst_n,
	input  wire  [xc_pkg::NUM_COUNTERS*xc_pkg::COUNT_WIDTH-1:0] counts,
	input  wire                                                  window_end,
	output logic [7:0]                                           pkt_data,
	output logic                                                 pkt_valid,
	output logic                                                 pkt_last,
	input  wire                                                  pkt_ready
);
	import xc_pkg::*;

	localparam logic [7:0] SHAPE_BYTE = 8'((NUM_LAGS << 4) | NUM_INPUTS);

	logic [NUM_COUNTERS-1:0][COUNT_WIDTH-1:0] snap_q;  // Counters at window end
	logic [7:0]                  win_cnt_q;  // Windows ended since reset
	logic [7:0]                  drop_q;     // Windows lost since last packet
	logic [7:0]                  hdr_idx_q;
	logic [7:0]                  hdr_drop_q;
	logic [BYTE_INDEX_WIDTH-1:0] byte_q;     // Byte on the bus
	logic                        valid_q;
	logic                        last_byte;

	assign last_byte = (byte_q == BYTE_INDEX_WIDTH'(PACKET_BYTES - 1));

	always_ff @(posedge RXIF) begin
		if (window_end && !valid_q) begin
			snap_q <= counts;
		end
	end

	always_ff @(posedge RXIF or negedge arst_n) begin
		if (!arst_n) begin
			win_cnt_q  <= '0;
			drop_q     <= '0;
			hdr_idx_q  <= '0;
			hdr_drop_q <= '0;
			byte_q     <= '0;
			valid_q    <= 1'b0;
		end else begin
			if (window_end) begin
				win_cnt_q <= win_cnt_q + 1'b1;
			end
			if (window_end && !valid_q) begin
				hdr_idx_q  <= win_cnt_q + 1'b1;  // Counts this window
				hdr_drop_q <= drop_q;
				drop_q     <= '0;
				byte_q     <= '0;
				valid_q    <= 1'b1;
			end else begin
				if (window_end && (drop_q != '1)) begin
					drop_q <= drop_q + 1'b1;     // Still busy streaming
				end
				if (valid_q && pkt_ready) begin
					if (last_byte) begin
						valid_q <= 1'b0;
					end else begin
						byte_q <= byte_q + 1'b1;
					end
				end
			end
		end
	end

	always_comb begin
		case (byte_q)
			BYTE_INDEX_WIDTH'(0): pkt_data = SYNC_BYTE;
			BYTE_INDEX_WIDTH'(1): pkt_data = hdr_idx_q;
			BYTE_INDEX_WIDTH'(2): pkt_data = SHAPE_BYTE;
			BYTE_INDEX_WIDTH'(3): pkt_data = hdr_drop_q;
			default: begin
				pkt_data = snap_q[byte_q - BYTE_INDEX_WIDTH'(HEADER_BYTES)];  // Payload
			end
		endcase
	end

	assign pkt_valid = valid_q;
	assign pkt_last  = valid_q & last_byte;

endmodule

`default_nettype wire

/* integration_timer.sv */
// Integration window timer
`timescale 1ns/1ps
`default_nettype none

module integration_timer (
	input  wire                                   RXIF,
	input  wire                                   arst_n,
	input  wire                                   capture,
	input  wire  [xc_pkg::WINDOW_SHIFT_WIDTH-1:0] window_shift,
	output logic                                  window_start,
	output logic                                  window_end
);
	import xc_pkg::*;

	logic                          running_q;
	logic                          start_q;
	logic                          end_q;
	logic [WINDOW_COUNT_WIDTH-1:0] cnt_q;      // Cycles since window start
	logic [WINDOW_COUNT_WIDTH-1:0] last_q;     // Final cycle of this window
	logic [WINDOW_COUNT_WIDTH-1:0] next_last;

	assign next_last = (WINDOW_COUNT_WIDTH'(WINDOW_BASE) << window_shift) - 1'b1;

	always_ff @(posedge RXIF or negedge arst_n) begin
		if (!arst_n) begin
			running_q <= 1'b0;
			start_q   <= 1'b0;
			end_q     <= 1'b0;
			cnt_q     <= '0;
			last_q    <= '0;
		end else begin
			start_q <= 1'b0;
			end_q   <= 1'b0;
			if (!capture) begin
				running_q <= 1'b0;
			end else if (!running_q) begin
				running_q <= 1'b1;       // First window
				start_q   <= 1'b1;
				cnt_q     <= '0;
				last_q    <= next_last;
			end else if (cnt_q == last_q) begin
				start_q <= 1'b1;         // Back-to-back window
				end_q   <= 1'b1;
				cnt_q   <= '0;
				last_q  <= next_last;    // Length picked up here
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	// Dropping capture silences any strobe already queued
	assign window_start = start_q & capture;
	assign window_end   = end_q & capture;

endmodule

`default_nettype wire

/* command_decoder.sv */
// Command byte decoder
`timescale 1ns/1ps
`default_nettype none

module command_decoder (
	input  wire                                                RXIF,
	input  wire                                                arst_n,
	input  wire  [7:0]                                         cmd_data,
	input  wire                                                cmd_valid,
	output logic [xc_pkg::NUM_INPUTS-1:0]                      line_invert,
	output logic [xc_pkg::NUM_INPUTS-1:0]                      line_level,
	output logic [xc_pkg::NUM_INPUTS*xc_pkg::DELAY_WIDTH-1:0] cross_delay,
	output logic [xc_pkg::NUM_INPUTS*xc_pkg::DELAY_WIDTH-1:0] auto_delay,
	output logic [xc_pkg::WINDOW_SHIFT_WIDTH-1:0]              window_shift,
	output logic                                               capture
);
	import xc_pkg::*;

	logic [LINE_WIDTH-1:0] line_q;  // Addressed line
	logic [3:0]            opcode;
	logic [3:0]            arg;

	assign opcode = cmd_data[3:0];
	assign arg    = cmd_data[7:4];

	always_ff @(posedge RXIF or negedge arst_n) begin
		if (!arst_n) begin
			line_q       <= '0;
			line_invert  <= '0;
			line_level   <= '0;  // Edge mode
			cross_delay  <= '0;
			auto_delay   <= '0;
			window_shift <= '0;
			capture      <= 1'b0;
		end else if (cmd_valid) begin
			case (opcode)
				OP_CLEAR: begin
					cross_delay[line_q*DELAY_WIDTH +: DELAY_WIDTH] <= '0;
					auto_delay[line_q*DELAY_WIDTH +: DELAY_WIDTH]  <= '0;
				end
				OP_SET_LINE: begin
					line_q <= LINE_WIDTH'(arg % NUM_INPUTS);  // Wraps onto a real line
				end
				OP_SET_MODE: begin
					line_invert[line_q] <= arg[0];
					line_level[line_q]  <= arg[1];
				end
				OP_SET_CROSS_DELAY: begin
					cross_delay[line_q*DELAY_WIDTH +: DELAY_WIDTH] <= arg[DELAY_WIDTH-1:0];
				end
				OP_SET_AUTO_DELAY: begin
					auto_delay[line_q*DELAY_WIDTH +: DELAY_WIDTH] <= arg[DELAY_WIDTH-1:0];
				end
				OP_SET_WINDOW: begin
					window_shift <= arg[WINDOW_SHIFT_WIDTH-1:0];
				end
				OP_ENABLE_CAPTURE: begin
					capture <= arg[0];
				end
				default: begin
					// Unknown opcode, nothing changes
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* correlator_core.sv */
// Coincidence counter array
`timescale 1ns/1ps
`default_nettype none

module correlator_core (
	input  wire                                                RXIF,
	input  wire                                                arst_n,
	input  wire  [xc_pkg::NUM_TAPS*xc_pkg::NUM_INPUTS-1:0]    taps,
	input  wire  [xc_pkg::NUM_INPUTS*xc_pkg::DELAY_WIDTH-1:0] cross_delay,
	input  wire  [xc_pkg::NUM_INPUTS*xc_pkg::DELAY_WIDTH-1:0] auto_delay,
	input  wire                                                window_start,
	output logic [xc_pkg::NUM_COUNTERS*xc_pkg::COUNT_WIDTH-1:0] counts
);
	import xc_pkg::*;

	wire  [DELAY_WIDTH-1:0] cd [NUM_INPUTS];  // Cross delay per line
	wire  [DELAY_WIDTH-1:0] ad [NUM_INPUTS];  // Auto delay per line
	wire  [NUM_COUNTERS-1:0] hit;             // Increment request per counter
	logic [NUM_COUNTERS-1:0][COUNT_WIDTH-1:0] cnt_q;

	// Bit of one line at tap k
	function automatic logic tap_at(
		input logic [NUM_TAPS*NUM_INPUTS-1:0] t,
		input int unsigned                    k,
		input int unsigned                    line
	);
		return t[k*NUM_INPUTS + line];
	endfunction

	for (genvar a = 0; a < NUM_INPUTS; a++) begin : g_line
		assign cd[a] = cross_delay[a*DELAY_WIDTH +: DELAY_WIDTH];
		assign ad[a] = auto_delay[a*DELAY_WIDTH +: DELAY_WIDTH];

		assign hit[a] = tap_at(taps, cd[a], a);  // Plain count
		assign hit[NUM_INPUTS + a] = tap_at(taps, cd[a], a)
			& tap_at(taps, int'(cd[a]) + int'(ad[a]), a);  // Against its own delayed copy
	end

	// Baselines a<b in order (0,1), (0,2), (1,2), lags -1, 0, +1
	for (genvar a = 0; a < NUM_INPUTS; a++) begin : g_base_a
		for (genvar b = a + 1; b < NUM_INPUTS; b++) begin : g_base_b
			localparam int BL  = a * (2 * NUM_INPUTS - a - 1) / 2 + b - a - 1;
			localparam int IDX = 2 * NUM_INPUTS + BL * NUM_LAGS;

			assign hit[IDX] = tap_at(taps, int'(cd[a]) + 1, a)
				& tap_at(taps, cd[b], b);  // b trails a by one cycle
			assign hit[IDX + 1] = tap_at(taps, cd[a], a) & tap_at(taps, cd[b], b);
			assign hit[IDX + 2] = tap_at(taps, cd[a], a)
				& tap_at(taps, int'(cd[b]) + 1, b);  // b leads a by one cycle
		end
	end

	always_ff @(posedge RXIF or negedge arst_n) begin
		if (!arst_n) begin
			cnt_q <= '0;
		end else begin
			for (int i = 0; i < NUM_COUNTERS; i++) begin
				if (window_start) begin
					cnt_q[i] <= COUNT_WIDTH'(hit[i]);  // New window starts from this cycle
				end else if (hit[i] && (cnt_q[i] != '1)) begin
					cnt_q[i] <= cnt_q[i] + 1'b1;       // Saturates at all ones
				end
			end
		end
	end

	assign counts = cnt_q;

endmodule

`default_nettype wire

/* tap_delay_line.sv */
// Pulse tap delay line
`timescale 1ns/1ps
`default_nettype none

module tap_delay_line (
	input  wire                                              RXIF,
	input  wire                                              arst_n,
	input  wire  [xc_pkg::NUM_INPUTS-1:0]                    pulses,
	output logic [xc_pkg::NUM_TAPS*xc_pkg::NUM_INPUTS-1:0]  taps
);
	import xc_pkg::*;

	localparam int CHAIN_BITS = (NUM_TAPS - 1) * NUM_INPUTS;

	logic [CHAIN_BITS-1:0] chain_q;  // Taps 1 and up, oldest at the top

	always_ff @(posedge RXIF or negedge arst_n) begin
		if (!arst_n) begin
			chain_q <= '0;
		end else begin
			chain_q <= {chain_q[CHAIN_BITS-NUM_INPUTS-1:0], pulses};
		end
	end

	assign taps = {chain_q, pulses};  // Tap 0 is the live pulse vector

endmodule

`default_nettype wire

/* pulse_conditioner.sv */
// Input line pulse conditioner
`timescale 1ns/1ps
`default_nettype none

module pulse_conditioner (
	input  wire                           RXIF,
	input  wire                           arst_n,
	input  wire  [xc_pkg::NUM_INPUTS-1:0] line_in,
	input  wire  [xc_pkg::NUM_INPUTS-1:0] line_invert,
	input  wire  [xc_pkg::NUM_INPUTS-1:0] line_level,
	output logic [xc_pkg::NUM_INPUTS-1:0] pulses
);
	import xc_pkg::*;

	logic [NUM_INPUTS-1:0] sync1_q;  // First synchronizer stage
	logic [NUM_INPUTS-1:0] sync2_q;  // Second synchronizer stage
	logic [NUM_INPUTS-1:0] prev_q;   // Level seen one cycle earlier
	logic [NUM_INPUTS-1:0] level;
	logic [NUM_INPUTS-1:0] rise;

	assign level = sync2_q ^ line_invert;  // Polarity-corrected line
	assign rise  = level & ~prev_q;

	always_ff @(posedge RXIF or negedge arst_n) begin
		if (!arst_n) begin
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q  <= '0;
			pulses  <= '0;
		end else begin
			sync1_q <= line_in;
			sync2_q <= sync1_q;
			prev_q  <= level;
			// Level mode passes the line, edge mode keeps rising edges only
			pulses  <= (line_level & level) | (~line_level & rise);
		end
	end

endmodule

`default_nettype wire

/* xc_pkg.sv */
// Correlator shared constants
`default_nettype none

package xc_pkg;

	// Array sizes
	localparam int NUM_INPUTS    = 3;
	localparam int NUM_BASELINES = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int NUM_LAGS      = 3;                          // Lags -1, 0, +1
	localparam int DELAY_WIDTH   = 3;
	localparam int MAX_DELAY     = 7;
	localparam int NUM_TAPS      = MAX_DELAY + MAX_DELAY + 2;  // Cross, auto and one lag
	localparam int COUNT_WIDTH   = 8;
	localparam int NUM_COUNTERS  = NUM_INPUTS + NUM_INPUTS + NUM_BASELINES * NUM_LAGS;
	localparam int LINE_WIDTH    = $clog2(NUM_INPUTS);

	// Command opcodes, low nibble of a command byte
	localparam logic [3:0] OP_CLEAR           = 4'd0;
	localparam logic [3:0] OP_SET_LINE        = 4'd1;
	localparam logic [3:0] OP_SET_MODE        = 4'd2;
	localparam logic [3:0] OP_SET_CROSS_DELAY = 4'd4;
	localparam logic [3:0] OP_SET_AUTO_DELAY  = 4'd5;
	localparam logic [3:0] OP_SET_WINDOW      = 4'd8;
	localparam logic [3:0] OP_ENABLE_CAPTURE  = 4'd13;

	// Window length is WINDOW_BASE << window_shift cycles
	localparam int WINDOW_SHIFT_WIDTH = 4;
	localparam int WINDOW_BASE        = 16;
	localparam int WINDOW_COUNT_WIDTH = 4 + (1 << WINDOW_SHIFT_WIDTH);

	// Packet layout
	localparam logic [7:0] SYNC_BYTE = 8'hA5;
	localparam int HEADER_BYTES      = 4;
	localparam int PACKET_BYTES      = HEADER_BYTES + NUM_COUNTERS;
	localparam int BYTE_INDEX_WIDTH  = $clog2(PACKET_BYTES);

endpackage

`default_nettype wire
